//--- logic/mips_pkg.sv
package mips_pkg;

  // ####################################################################
  // widths
  // ####################################################################
  localparam int DWIDTH = 16;   // data and pc.
  localparam int AWIDTH = 32;   // bus address.
  localparam int IWIDTH = 32;   // instruction word.
  localparam int RWIDTH = 5;    // register index.
  localparam int NREGS  = 32;

  localparam logic [RWIDTH-1:0] LINK_REG = 5'd31;   // jal target register.

  // ####################################################################
  // instruction encodings
  // ####################################################################
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    F_JR   = 6'h08,
    F_MFHI = 6'h10,
    F_MFLO = 6'h12,
    F_MULT = 6'h18,
    F_ADD  = 6'h20,
    F_SUB  = 6'h22,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_op_t;

  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;   // also the jump target.
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  // ####################################################################
  // decoded controls
  // ####################################################################
  typedef struct packed {
    logic    memtoreg;
    logic    memwrite;
    logic    memop;
    logic    branch;
    logic    alusrc;
    logic    regdst;
    logic    regwrite;
    logic    jump;
    logic    jumpreg;
    logic    link;
    logic    mult;
    logic    mfhi;
    logic    mflo;
    alu_op_t alucontrol;
  } ctrl_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  logic [DWIDTH-1:0] a,
  input  logic [DWIDTH-1:0] b,
  input  alu_op_t           alucontrol,
  output logic [DWIDTH-1:0] y,
  output logic              zero
);

  logic              sub;
  logic [DWIDTH-1:0] b_eff;
  logic [DWIDTH-1:0] sum;
  logic              slt;

  // ####################################################################
  // shared adder for add, sub and slt
  // ####################################################################
  assign sub   = (alucontrol == ALU_SUB) || (alucontrol == ALU_SLT);
  assign b_eff = sub ? ~b : b;
  assign sum   = a + b_eff + DWIDTH'(sub);   // two's complement subtract.

  // signed less-than, corrected for overflow.
  assign slt = (a[DWIDTH-1] != b[DWIDTH-1]) ? a[DWIDTH-1] : sum[DWIDTH-1];

  always_comb begin
    case (alucontrol)
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_ADD: y = sum;
      ALU_SUB: y = sum;
      ALU_SLT: y = {{(DWIDTH-1){1'b0}}, slt};
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);   // beq compare.

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  logic [RWIDTH-1:0] ra1,
  input  logic [RWIDTH-1:0] ra2,
  input  logic [RWIDTH-1:0] wa,
  input  logic [DWIDTH-1:0] wd,
  input  logic [RWIDTH-1:0] debug_ra4,
  output logic [DWIDTH-1:0] rd1,
  output logic [DWIDTH-1:0] rd2,
  output logic [DWIDTH-1:0] debug_rd4
);

  logic [DWIDTH-1:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin   // r0 is never written.
      regs[wa] <= wd;
    end
  end

  assign rd1       = regs[ra1];
  assign rd2       = regs[ra2];
  assign debug_rd4 = regs[debug_ra4];

  // r0 stays zero across any write sequence.
  r0_reads_zero: assert property (@(posedge clk) disable iff (rst)
                                  debug_ra4 == '0 |-> debug_rd4 == '0);

endmodule

//--- logic/controller.sv
`timescale 1ns/1ps

module controller import mips_pkg::*; (
  input  instr_t instr,
  output ctrl_t  ctrl,
  output logic   memop
);

  always_comb begin
    ctrl = '0;
    case (instr.i.op)
      OP_RTYPE: begin
        ctrl.regdst = 1'b1;
        case (instr.r.funct)
          F_ADD: begin
            ctrl.regwrite   = 1'b1;
            ctrl.alucontrol = ALU_ADD;
          end
          F_SUB: begin
            ctrl.regwrite   = 1'b1;
            ctrl.alucontrol = ALU_SUB;
          end
          F_AND: begin
            ctrl.regwrite   = 1'b1;
            ctrl.alucontrol = ALU_AND;
          end
          F_OR: begin
            ctrl.regwrite   = 1'b1;
            ctrl.alucontrol = ALU_OR;
          end
          F_SLT: begin
            ctrl.regwrite   = 1'b1;
            ctrl.alucontrol = ALU_SLT;
          end
          F_JR:   ctrl.jumpreg = 1'b1;
          F_MULT: ctrl.mult    = 1'b1;   // hi/lo only, no gpr write.
          F_MFHI: begin
            ctrl.regwrite = 1'b1;
            ctrl.mfhi     = 1'b1;
          end
          F_MFLO: begin
            ctrl.regwrite = 1'b1;
            ctrl.mflo     = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      OP_ADDI: begin
        ctrl.regwrite   = 1'b1;
        ctrl.alusrc     = 1'b1;
        ctrl.alucontrol = ALU_ADD;
      end
      OP_LW: begin
        ctrl.regwrite   = 1'b1;
        ctrl.alusrc     = 1'b1;
        ctrl.memtoreg   = 1'b1;
        ctrl.memop      = 1'b1;
        ctrl.alucontrol = ALU_ADD;   // base plus offset.
      end
      OP_SW: begin
        ctrl.alusrc     = 1'b1;
        ctrl.memwrite   = 1'b1;
        ctrl.memop      = 1'b1;
        ctrl.alucontrol = ALU_ADD;
      end
      OP_BEQ: begin
        ctrl.branch     = 1'b1;
        ctrl.alucontrol = ALU_SUB;   // zero flag on equal.
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  assign memop = ctrl.memop;

  always_comb begin
    assert (!(ctrl.mfhi && ctrl.mflo)) else $error("mfhi and mflo decoded together.");
  end

endmodule

//--- logic/bus_interface.sv
`timescale 1ns/1ps

module bus_interface import mips_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              memop,
  input  logic              memtoreg,
  input  logic              bus_ack,
  input  logic              bus_wait,
  input  logic [DWIDTH-1:0] bus_rdata,
  output logic              bus_req,
  output logic              pc_stall,
  output logic [DWIDTH-1:0] readdata
);

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_DRAIN1, S_DRAIN2} state_t;

  state_t            state;
  state_t            state_next;
  logic              accept;
  logic [DWIDTH-1:0] rdata_q;

  assign bus_req = memop && (state == S_IDLE || state == S_WAIT);
  assign accept  = bus_req && bus_ack && !bus_wait;   // ack only counts without wait.

  // a store is released in its accepting cycle, a load waits for the delay line.
  assign pc_stall = (bus_req && !(accept && !memtoreg)) || state == S_DRAIN1;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE, S_WAIT: begin
        if (accept) begin
          state_next = memtoreg ? S_DRAIN1 : S_IDLE;
        end else if (bus_req) begin
          state_next = S_WAIT;
        end
      end
      S_DRAIN1: state_next = S_DRAIN2;
      S_DRAIN2: state_next = S_IDLE;   // load writes back here.
      default:  state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      rdata_q  <= '0;
      readdata <= '0;
    end else begin
      state    <= state_next;
      rdata_q  <= bus_rdata;   // two-stage read delay.
      readdata <= rdata_q;
    end
  end

  req_held:  assert property (@(posedge clk) disable iff (rst)
                              bus_req && !accept |=> bus_req);
  load_held: assert property (@(posedge clk) disable iff (rst)
                              state inside {S_DRAIN1, S_DRAIN2} |-> memop && memtoreg);

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ps

module datapath import mips_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  ctrl_t             ctrl,
  input  instr_t            instr,
  input  logic [DWIDTH-1:0] readdata,
  input  logic              pc_stall,
  input  logic [RWIDTH-1:0] debug_ra4,
  output logic [DWIDTH-1:0] pc,
  output logic [AWIDTH-1:0] bus_addr,
  output logic [DWIDTH-1:0] bus_wdata,
  output logic [DWIDTH-1:0] debug_rd4
);

  logic [DWIDTH-1:0]   imm;
  logic [DWIDTH-1:0]   pcplus1;
  logic [DWIDTH-1:0]   pcbranch;
  logic [DWIDTH-1:0]   pcnext;
  logic                pcsrc;
  logic [DWIDTH-1:0]   rd1;
  logic [DWIDTH-1:0]   rd2;
  logic [DWIDTH-1:0]   srcb;
  logic [DWIDTH-1:0]   aluout;
  logic                zero;
  logic [RWIDTH-1:0]   writereg;
  logic [DWIDTH-1:0]   result;
  logic                regwe;
  logic [DWIDTH-1:0]   hi;
  logic [DWIDTH-1:0]   lo;
  logic [2*DWIDTH-1:0] product;

  assign imm = instr.i.imm;

  // ####################################################################
  // next pc
  // ####################################################################
  assign pcplus1  = pc + DWIDTH'(1);
  assign pcbranch = pcplus1 + imm;
  assign pcsrc    = ctrl.branch && zero;

  always_comb begin
    if (ctrl.jumpreg) begin
      pcnext = rd1;   // jr.
    end else if (ctrl.jump) begin
      pcnext = imm;
    end else if (pcsrc) begin
      pcnext = pcbranch;
    end else begin
      pcnext = pcplus1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!pc_stall) begin
      pc <= pcnext;
    end
  end

  // ####################################################################
  // register file, alu and write back
  // ####################################################################
  assign writereg = ctrl.link   ? LINK_REG :
                    ctrl.regdst ? instr.r.rd : instr.r.rt;
  assign regwe    = ctrl.regwrite && !pc_stall;   // held while the bus is busy.
  assign srcb     = ctrl.alusrc ? imm : rd2;

  always_comb begin
    if (ctrl.link) begin
      result = pcplus1;
    end else if (ctrl.mfhi) begin
      result = hi;
    end else if (ctrl.mflo) begin
      result = lo;
    end else if (ctrl.memtoreg) begin
      result = readdata;
    end else begin
      result = aluout;
    end
  end

  register_file rf_i (
    .clk       (clk),
    .rst       (rst),
    .we        (regwe),
    .ra1       (instr.r.rs),
    .ra2       (instr.r.rt),
    .wa        (writereg),
    .wd        (result),
    .debug_ra4 (debug_ra4),
    .rd1       (rd1),
    .rd2       (rd2),
    .debug_rd4 (debug_rd4)
  );

  alu alu_i (
    .a          (rd1),
    .b          (srcb),
    .alucontrol (ctrl.alucontrol),
    .y          (aluout),
    .zero       (zero)
  );

  // signed 16x16 product into hi/lo.
  assign product = $signed(rd1) * $signed(rd2);

  always_ff @(posedge clk) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (ctrl.mult && !pc_stall) begin
      hi <= product[2*DWIDTH-1:DWIDTH];
      lo <= product[DWIDTH-1:0];
    end
  end

  assign bus_addr  = {{(AWIDTH-DWIDTH){1'b0}}, aluout};   // zero extended.
  assign bus_wdata = rd2;

endmodule

//--- logic/mips.sv
`timescale 1ns/1ps

module mips import mips_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [IWIDTH-1:0] instr,
  input  logic              bus_ack,
  input  logic              bus_wait,
  input  logic [DWIDTH-1:0] bus_rdata,
  input  logic [RWIDTH-1:0] debug_ra4,
  output logic [DWIDTH-1:0] pc,
  output logic              bus_write,
  output logic [AWIDTH-1:0] bus_addr,
  output logic [DWIDTH-1:0] bus_wdata,
  output logic              bus_req,
  output logic [DWIDTH-1:0] debug_rd4
);

  ctrl_t             ctrl;
  logic              memop;
  logic              pc_stall;
  logic [DWIDTH-1:0] readdata;

  assign bus_write = ctrl.memwrite;   // low unless sw.

  controller ctrl_i (
    .instr (instr),
    .ctrl  (ctrl),
    .memop (memop)
  );

  bus_interface bus_if_i (
    .clk       (clk),
    .rst       (rst),
    .memop     (memop),
    .memtoreg  (ctrl.memtoreg),
    .bus_ack   (bus_ack),
    .bus_wait  (bus_wait),
    .bus_rdata (bus_rdata),
    .bus_req   (bus_req),
    .pc_stall  (pc_stall),
    .readdata  (readdata)
  );

  datapath dp_i (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .instr     (instr),
    .readdata  (readdata),
    .pc_stall  (pc_stall),
    .debug_ra4 (debug_ra4),
    .pc        (pc),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .debug_rd4 (debug_rd4)
  );

endmodule

//--- include/mips_tb_tasks.svh
`ifndef MIPS_TB_TASKS_SVH
`define MIPS_TB_TASKS_SVH

function automatic logic [31:0] enc_r(funct_t f, logic [4:0] rs, logic [4:0] rt,
                                      logic [4:0] rd);
  return {OP_RTYPE, rs, rt, rd, 5'd0, f};
endfunction

function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(opcode_t op, logic [15:0] target);
  return {op, 5'd0, 5'd0, target};
endfunction

function automatic int count_pc(logic [15:0] v);
  int n;
  n = 0;
  foreach (cyc_trace[k]) begin
    if (cyc_trace[k] == v) n++;
  end
  return n;
endfunction

task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  assert (got === exp) else begin
    $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
    error_count++;
  end
endtask

task automatic check_true(input logic cond, input string what);
  check_count++;
  assert (cond) else begin
    $display("ERROR time=%0t %s", $time, what);
    error_count++;
  end
endtask

task automatic clear_prog();
  for (int a = 0; a < 256; a++) begin
    prog[a] = enc_j(OP_J, 16'(a));   // every slot spins on itself.
  end
endtask

task automatic apply_reset();
  @(negedge clk);
  rst = 1'b1;
  repeat (4) @(negedge clk);
  rst = 1'b0;
endtask

task automatic run_to(input logic [15:0] end_pc);
  cyc_trace.delete();
  st_addr.delete();
  st_data.delete();
  wait_log.delete();
  @(posedge clk);
  while (pc !== end_pc) begin
    cyc_trace.push_back(pc);
    if (bus_req && bus_write) begin
      st_addr.push_back(bus_addr);
      st_data.push_back(bus_wdata);
    end
    @(posedge clk);
  end
endtask

task automatic check_reg(input logic [4:0] idx, input logic [15:0] exp);
  @(negedge clk);
  debug_ra4 = idx;
  @(posedge clk);
  check_eq($sformatf("r%0d", idx), 32'(debug_rd4), 32'(exp));
endtask

task automatic end_test(input string name, input int errs_before);
  if (error_count == errs_before) begin
    $display("test %s: passed", name);
  end else begin
    $display("test %s: failed with %0d errors", name, error_count - errs_before);
    failed_tests++;
  end
endtask

// ######################################################################
// directed tests
// ######################################################################
task automatic test_reset();
  int e;
  e = error_count;
  clear_prog();
  prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, 16'd5);
  apply_reset();
  @(posedge clk);
  check_eq("pc", 32'(pc), 32'd0);
  check_eq("bus_req", 32'(bus_req), 32'd0);
  check_eq("bus_write", 32'(bus_write), 32'd0);
  end_test("reset", e);
endtask

task automatic test_arith();
  int e;
  logic [15:0] a;
  logic [15:0] b;
  e = error_count;
  a = lcg_next();
  b = lcg_next();
  clear_prog();
  prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, a);
  prog[1] = enc_i(OP_ADDI, 5'd0, 5'd2, b);
  prog[2] = enc_r(F_ADD, 5'd1, 5'd2, 5'd3);
  prog[3] = enc_r(F_SUB, 5'd1, 5'd2, 5'd4);
  prog[4] = enc_r(F_AND, 5'd1, 5'd2, 5'd5);
  prog[5] = enc_r(F_OR, 5'd1, 5'd2, 5'd6);
  prog[6] = enc_r(F_SLT, 5'd1, 5'd2, 5'd7);
  prog[7] = enc_i(OP_ADDI, 5'd1, 5'd0, 16'd7);   // write to r0.
  apply_reset();
  run_to(16'd8);
  check_reg(5'd1, a);
  check_reg(5'd2, b);
  check_reg(5'd3, a + b);
  check_reg(5'd4, a - b);
  check_reg(5'd5, a & b);
  check_reg(5'd6, a | b);
  check_reg(5'd7, ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
  check_reg(5'd0, 16'd0);
  end_test("arith", e);
endtask

task automatic test_control();
  int e;
  logic [15:0] seen[$];
  logic [15:0] exp[$];
  e = error_count;
  clear_prog();
  prog[0]  = enc_i(OP_ADDI, 5'd0, 5'd1, 16'd3);
  prog[1]  = enc_i(OP_ADDI, 5'd0, 5'd2, 16'd3);
  prog[2]  = enc_i(OP_BEQ, 5'd1, 5'd2, 16'd2);   // taken.
  prog[3]  = enc_i(OP_ADDI, 5'd0, 5'd10, 16'd1);
  prog[4]  = enc_i(OP_ADDI, 5'd0, 5'd10, 16'd2);
  prog[5]  = enc_i(OP_BEQ, 5'd1, 5'd0, 16'd5);   // not taken.
  prog[6]  = enc_j(OP_J, 16'd8);
  prog[7]  = enc_i(OP_ADDI, 5'd0, 5'd11, 16'd1);
  prog[8]  = enc_j(OP_JAL, 16'd12);
  prog[9]  = enc_j(OP_J, 16'd14);
  prog[12] = enc_r(F_JR, 5'd31, 5'd0, 5'd0);
  exp = '{16'd0, 16'd1, 16'd2, 16'd2 + 16'd1 + 16'd2, 16'd5 + 16'd1, 16'd8,
          16'd12, 16'd8 + 16'd1, 16'd14};
  apply_reset();
  run_to(16'd14);
  foreach (cyc_trace[k]) begin
    if (seen.size() == 0 || seen[$] != cyc_trace[k]) seen.push_back(cyc_trace[k]);
  end
  seen.push_back(16'd14);
  check_eq("pc trace length", 32'(seen.size()), 32'(exp.size()));
  foreach (exp[k]) begin
    if (k < seen.size()) check_eq($sformatf("pc[%0d]", k), 32'(seen[k]), 32'(exp[k]));
  end
  check_reg(5'd31, 16'd9);
  check_reg(5'd10, 16'd0);
  check_reg(5'd11, 16'd0);
  end_test("control", e);
endtask

task automatic test_mult();
  int e;
  logic [15:0] a;
  logic [15:0] b;
  logic [31:0] prod;
  e = error_count;
  a = lcg_next();
  b = lcg_next();
  prod = $signed(a) * $signed(b);
  clear_prog();
  prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, a);
  prog[1] = enc_i(OP_ADDI, 5'd0, 5'd2, b);
  prog[2] = enc_r(F_MULT, 5'd1, 5'd2, 5'd0);
  prog[3] = enc_r(F_MFHI, 5'd0, 5'd0, 5'd3);
  prog[4] = enc_r(F_MFLO, 5'd0, 5'd0, 5'd4);
  apply_reset();
  run_to(16'd5);
  check_reg(5'd3, prod[31:16]);
  check_reg(5'd4, prod[15:0]);
  end_test("mult", e);
endtask

task automatic test_store();
  int e;
  logic [15:0] base;
  logic [15:0] off;
  logic [15:0] val;
  logic [15:0] addr;
  e = error_count;
  base = lcg_next() & 16'h00f0;
  off  = lcg_next() & 16'h000f;
  val  = lcg_next();
  addr = base + off;
  clear_prog();
  prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, base);
  prog[1] = enc_i(OP_ADDI, 5'd0, 5'd2, val);
  prog[2] = enc_i(OP_SW, 5'd1, 5'd2, off);
  apply_reset();
  run_to(16'd3);
  check_true(st_addr.size() > 0, "no store request was seen on the bus");
  foreach (st_addr[k]) begin
    check_eq("bus_addr", st_addr[k], 32'(addr));
    check_eq("bus_wdata", 32'(st_data[k]), 32'(val));
  end
  check_true(wait_log.size() == 1, "store did not make exactly one bus request");
  if (wait_log.size() == 1) check_eq("store hold", 32'(count_pc(16'd2)), 32'(2 + wait_log[0]));
  check_eq("dmem", 32'(dmem[addr[7:0]]), 32'(val));
  end_test("store", e);
endtask

task automatic test_load();
  int e;
  logic [15:0] base;
  logic [15:0] off1;
  logic [15:0] off2;
  logic [15:0] d1;
  logic [15:0] d2;
  e = error_count;
  base = lcg_next() & 16'h00f0;
  off1 = lcg_next() & 16'h0007;
  off2 = 16'd8 + (lcg_next() & 16'h0007);
  d1 = dmem[8'(base + off1)];
  d2 = dmem[8'(base + off2)];
  clear_prog();
  prog[0] = enc_i(OP_ADDI, 5'd0, 5'd1, base);
  prog[1] = enc_i(OP_LW, 5'd1, 5'd2, off1);
  prog[2] = enc_i(OP_LW, 5'd1, 5'd4, off2);
  prog[3] = enc_r(F_ADD, 5'd2, 5'd4, 5'd3);   // uses both loads.
  apply_reset();
  run_to(16'd4);
  check_true(wait_log.size() == 2, "loads did not make exactly two bus requests");
  if (wait_log.size() == 2) begin
    check_eq("load1 hold", 32'(count_pc(16'd1)), 32'(4 + wait_log[0]));
    check_eq("load2 hold", 32'(count_pc(16'd2)), 32'(4 + wait_log[1]));
  end
  check_reg(5'd2, d1);
  check_reg(5'd4, d2);
  check_reg(5'd3, d1 + d2);
  end_test("load", e);
endtask

`endif

//--- testbench/mips_tb.sv
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

  localparam int N_TESTS     = 6;
  localparam int CLK_PERIOD  = 40;
  localparam int WATCHDOG_NS = N_TESTS * 64 * 8 * CLK_PERIOD;

  logic              clk;
  logic              rst;
  logic [IWIDTH-1:0] instr;
  logic              bus_ack;
  logic              bus_wait;
  logic [DWIDTH-1:0] bus_rdata;
  logic [RWIDTH-1:0] debug_ra4;
  logic [DWIDTH-1:0] pc;
  logic              bus_write;
  logic [AWIDTH-1:0] bus_addr;
  logic [DWIDTH-1:0] bus_wdata;
  logic              bus_req;
  logic [DWIDTH-1:0] debug_rd4;

  logic [IWIDTH-1:0] prog [256];
  logic [DWIDTH-1:0] dmem [256];
  int unsigned       lcg_state = 80;
  logic [DWIDTH-1:0] cyc_trace[$];   // pc seen at every rising edge.
  logic [AWIDTH-1:0] st_addr[$];
  logic [DWIDTH-1:0] st_data[$];
  int                wait_log[$];    // wait cycles per bus request.
  logic              pending;
  int                waits_left;
  int                error_count;
  int                check_count;
  int                failed_tests;

  mips mips_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .bus_ack   (bus_ack),
    .bus_wait  (bus_wait),
    .bus_rdata (bus_rdata),
    .debug_ra4 (debug_ra4),
    .pc        (pc),
    .bus_write (bus_write),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_req   (bus_req),
    .debug_rd4 (debug_rd4)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // ####################################################################
  // instruction memory and bus slave
  // ####################################################################
  always @(posedge clk) begin
    if (rst) begin
      pending = 1'b0;
    end else if (bus_req && bus_ack && !bus_wait) begin
      if (bus_write) begin
        dmem[bus_addr[7:0]] = bus_wdata;
      end
      pending = 1'b0;
    end else if (bus_req && !pending) begin
      pending    = 1'b1;   // answered from the next cycle on.
      waits_left = int'(lcg_next() & 16'h3);
      wait_log.push_back(waits_left);
    end
  end

  always @(negedge clk) begin
    instr = prog[pc[7:0]];
    if (pending && waits_left > 0) begin
      bus_ack    = 1'b1;   // ack ignored while wait is high.
      bus_wait   = 1'b1;
      waits_left = waits_left - 1;
    end else if (pending) begin
      bus_ack   = 1'b1;
      bus_wait  = 1'b0;
      bus_rdata = dmem[bus_addr[7:0]];
    end else begin
      bus_ack  = 1'b0;
      bus_wait = 1'b0;
    end
  end

  `include "mips_tb_tasks.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    instr     = '0;
    bus_ack   = 1'b0;
    bus_wait  = 1'b0;
    bus_rdata = '0;
    debug_ra4 = '0;
    pending   = 1'b0;
    waits_left   = 0;
    error_count  = 0;
    check_count  = 0;
    failed_tests = 0;
    for (int a = 0; a < 256; a++) begin
      dmem[a] = 16'(a * 16'h0101) ^ 16'h5a3c;
    end
    test_reset();
    test_arith();
    test_control();
    test_mult();
    test_store();
    test_load();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             N_TESTS, failed_tests, check_count, error_count);
    if (error_count == 0 && failed_tests == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- mips.f
+incdir+include
logic/mips_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/controller.sv
logic/bus_interface.sv
logic/datapath.sv
logic/mips.sv
testbench/mips_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= mips.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
